//--- include/decodeStage_cfg.svh
`ifndef DECODE_STAGE_CFG_SVH
`define DECODE_STAGE_CFG_SVH

// Width of registers, PC and extended immediates
`define DATA_WIDTH 16

// General-purpose register file size
`define REG_COUNT 8

// Bits needed to address one register
`define REG_IDX_W 3

`endif

//--- logic/branchResolve.sv
`timescale 1ns/1ps
`include "decodeStage_cfg.svh"

module branchResolve
    import pipePkg::*;
(
    input  ctrlT                   ctrl,
    input  logic [`REG_IDX_W-1:0]  rs,
    input  logic [`DATA_WIDTH-1:0] rsData,
    input  fwdSrcT                 exFwd,
    input  fwdSrcT                 memFwd,
    input  logic [`DATA_WIDTH-1:0] pcInc,
    input  logic [`DATA_WIDTH-1:0] imm,
    output logic                   taken,
    output logic [`DATA_WIDTH-1:0] pcNew
);

    logic [`DATA_WIDTH-1:0] rsFwd;
    logic [`DATA_WIDTH-1:0] base;
    logic                   exHit;
    logic                   memHit;
    logic                   condMet;
    logic                   regJump;

    assign exHit  = exFwd.writes && (exFwd.rd == rs);
    assign memHit = memFwd.writes && (memFwd.rd == rs);

    // Youngest producer wins
    always_comb begin
        if (exHit) begin
            rsFwd = exFwd.data;
        end else if (memHit) begin
            rsFwd = memFwd.data;
        end else begin
            rsFwd = rsData;
        end
    end

    // Compare with zero
    always_comb begin
        unique case (ctrl.branchCtl)
            BR_EQZ:  condMet = (rsFwd == '0);
            BR_NEZ:  condMet = (rsFwd != '0);
            BR_LTZ:  condMet = rsFwd[`DATA_WIDTH-1];
            BR_GEZ:  condMet = !rsFwd[`DATA_WIDTH-1];
            default: condMet = 1'b0;
        endcase
    end

    assign regJump = ctrl.jumpCtl[2] && ctrl.jumpCtl[0];

    // jr and jalr are relative to rs, everything else to the next PC
    assign base  = regJump ? rsFwd : pcInc;
    assign pcNew = base + imm;

    assign taken = ctrl.jumpCtl[2] || condMet;

endmodule

//--- logic/controlDecode.sv
`timescale 1ns/1ps
`include "decodeStage_cfg.svh"

module controlDecode
    import isaPkg::*, pipePkg::*;
(
    input  instrWordT             instr,
    output ctrlT                  ctrl,
    output logic [`REG_IDX_W-1:0] rd
);

    logic isRFmt;
    logic isStu;

    always_comb begin
        ctrl           = '0;
        ctrl.aluOp     = ALU_ADD;
        ctrl.jumpCtl   = JMP_NONE;
        ctrl.branchCtl = BR_NONE;
        isRFmt         = 1'b0;
        isStu          = 1'b0;
        unique case (instr.rFmt.opcode)
            OP_HALT: ctrl.halt = 1'b1;
            OP_NOP: ;
            // Immediate ALU forms
            OP_ADDI, OP_SUBI, OP_XORI, OP_ANDNI,
            OP_ROLI, OP_SLLI, OP_RORI, OP_SRLI: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                unique case (instr.rFmt.opcode)
                    OP_SUBI:  ctrl.aluOp = ALU_SUB;
                    OP_XORI:  ctrl.aluOp = ALU_XOR;
                    OP_ANDNI: ctrl.aluOp = ALU_ANDN;
                    OP_ROLI:  ctrl.aluOp = ALU_ROT;
                    OP_SLLI:  ctrl.aluOp = ALU_SHL;
                    OP_SRLI:  ctrl.aluOp = ALU_SHR;
                    OP_RORI: begin
                        ctrl.aluOp = ALU_ROT;
                        ctrl.ror   = 1'b1;
                    end
                    default:  ctrl.aluOp = ALU_ADD;
                endcase
            end
            // Memory ops compute the address as rs plus imm
            OP_ST: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.memWrite = 1'b1;
            end
            OP_STU: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.memWrite = 1'b1;
                ctrl.regWrite = 1'b1;
                isStu         = 1'b1;
            end
            OP_LD: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.memRead  = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            OP_BTR: begin
                ctrl.btr      = 1'b1;
                ctrl.regWrite = 1'b1;
                isRFmt        = 1'b1;
            end
            OP_ALU, OP_SHFT: begin
                ctrl.regWrite = 1'b1;
                isRFmt        = 1'b1;
                if (instr.rFmt.opcode == OP_ALU) begin
                    unique case (instr.rFmt.func)
                        FN_ADD:  ctrl.aluOp = ALU_ADD;
                        FN_SUB:  ctrl.aluOp = ALU_SUB;
                        FN_XOR:  ctrl.aluOp = ALU_XOR;
                        FN_ANDN: ctrl.aluOp = ALU_ANDN;
                        default: ctrl.aluOp = ALU_ADD;
                    endcase
                end else begin
                    unique case (instr.rFmt.func)
                        FN_ROL:  ctrl.aluOp = ALU_ROT;
                        FN_SLL:  ctrl.aluOp = ALU_SHL;
                        FN_SRL:  ctrl.aluOp = ALU_SHR;
                        FN_ROR:  ctrl.aluOp = ALU_ROT;
                        default: ctrl.aluOp = ALU_ROT;
                    endcase
                    ctrl.ror = (instr.rFmt.func == FN_ROR);
                end
            end
            // Set-on-compare group, sle is the union of sl and seq
            OP_SEQ, OP_SLT, OP_SLE, OP_SCO: begin
                ctrl.regWrite = 1'b1;
                isRFmt        = 1'b1;
                ctrl.aluOp    = (instr.rFmt.opcode == OP_SCO) ? ALU_ADD : ALU_CMP;
                ctrl.seq      = (instr.rFmt.opcode == OP_SEQ) || (instr.rFmt.opcode == OP_SLE);
                ctrl.sl       = (instr.rFmt.opcode == OP_SLT) || (instr.rFmt.opcode == OP_SLE);
                ctrl.sco      = (instr.rFmt.opcode == OP_SCO);
            end
            OP_BEQZ: ctrl.branchCtl = BR_EQZ;
            OP_BNEZ: ctrl.branchCtl = BR_NEZ;
            OP_BLTZ: ctrl.branchCtl = BR_LTZ;
            OP_BGEZ: ctrl.branchCtl = BR_GEZ;
            OP_LBI: begin
                ctrl.lbi      = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            OP_SLBI: begin
                ctrl.slbi     = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            OP_J:  ctrl.jumpCtl = JMP_J;
            OP_JR: ctrl.jumpCtl = JMP_JR;
            OP_JAL, OP_JALR: begin
                ctrl.jumpCtl  = (instr.rFmt.opcode == OP_JAL) ? JMP_JAL : JMP_JALR;
                ctrl.link     = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            default: ctrl.illegal = 1'b1;
        endcase
    end

    // Destination register choice
    always_comb begin
        if (isStu || ctrl.lbi || ctrl.slbi) begin
            rd = instr.iFmt.rs;
        end else if (ctrl.link) begin
            rd = `REG_IDX_W'(`REG_COUNT - 1);
        end else if (isRFmt) begin
            rd = instr.rFmt.rd;
        end else begin
            rd = instr.iFmt.rd;
        end
    end

endmodule

//--- logic/decodeStage.sv
`timescale 1ns/1ps
`include "decodeStage_cfg.svh"

module decodeStage
    import isaPkg::*, pipePkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   inValid,
    output logic                   inReady,
    input  instrWordT              instr,
    input  logic [`DATA_WIDTH-1:0] pcInc,
    input  wbPortT                 wb,
    input  fwdSrcT                 exFwd,
    input  fwdSrcT                 memFwd,
    output logic                   dxValid,
    input  logic                   dxReady,
    output dxBundleT               dx,
    output logic                   redirect,
    output logic [`DATA_WIDTH-1:0] pcNew
);

    ctrlT                   ctrl;
    logic [`REG_IDX_W-1:0]  rdSel;
    logic [`DATA_WIDTH-1:0] rsData;
    logic [`DATA_WIDTH-1:0] rtData;
    logic [`DATA_WIDTH-1:0] immVal;
    logic                   taken;
    logic                   accept;

    regFileBypass u_regFile (
        .clk     (clk),
        .reset   (reset),
        .rdSelA  (instr.rFmt.rs),
        .rdSelB  (instr.rFmt.rt),
        .rdDataA (rsData),
        .rdDataB (rtData),
        .wb      (wb)
    );

    controlDecode u_ctrl (
        .instr (instr),
        .ctrl  (ctrl),
        .rd    (rdSel)
    );

    immExtend u_imm (
        .instr (instr),
        .ctrl  (ctrl),
        .imm   (immVal)
    );

    branchResolve u_branch (
        .ctrl   (ctrl),
        .rs     (instr.rFmt.rs),
        .rsData (rsData),
        .exFwd  (exFwd),
        .memFwd (memFwd),
        .pcInc  (pcInc),
        .imm    (immVal),
        .taken  (taken),
        .pcNew  (pcNew)
    );

    // Output slot frees up in the same cycle it drains
    assign inReady  = !dxValid || dxReady;
    assign accept   = inValid && inReady;
    assign redirect = accept && taken;

    always_ff @(posedge clk) begin
        if (reset) begin
            dxValid <= 1'b0;
        end else if (inReady) begin
            dxValid <= inValid;
        end
    end

    // Decode-to-execute register
    always_ff @(posedge clk) begin
        if (accept) begin
            dx.ctrl   <= ctrl;
            dx.rd     <= rdSel;
            dx.rs     <= instr.rFmt.rs;
            dx.rt     <= instr.rFmt.rt;
            dx.rsData <= rsData;
            dx.rtData <= rtData;
            dx.imm    <= immVal;
            dx.pcInc  <= pcInc;
        end
    end

endmodule

//--- logic/immExtend.sv
`timescale 1ns/1ps
`include "decodeStage_cfg.svh"

module immExtend
    import isaPkg::*, pipePkg::*;
(
    input  instrWordT              instr,
    input  ctrlT                   ctrl,
    output logic [`DATA_WIDTH-1:0] imm
);

    logic [10:0] imm11;
    logic [7:0]  imm8;
    logic [4:0]  imm5;
    logic        useImm11;
    logic        useImm8;
    logic        zeroExt;

    assign imm11 = {instr.iFmt.rs, instr.iFmt.rd, instr.iFmt.imm};
    assign imm8  = {instr.iFmt.rd, instr.iFmt.imm};
    assign imm5  = instr.iFmt.imm;

    // Direct jumps carry 11 bits
    assign useImm11 = ctrl.jumpCtl[2] && !ctrl.jumpCtl[0];

    // Branches, byte loads and register jumps carry 8 bits
    assign useImm8 = ctrl.branchCtl[2] || ctrl.lbi || ctrl.slbi
                   || (ctrl.jumpCtl[2] && ctrl.jumpCtl[0]);

    // Logical immediates and the shifted byte are unsigned
    assign zeroExt = ctrl.slbi
                   || (instr.iFmt.opcode == OP_XORI)
                   || (instr.iFmt.opcode == OP_ANDNI);

    always_comb begin
        if (useImm11) begin
            imm = {{(`DATA_WIDTH - 11){imm11[10] & ~zeroExt}}, imm11};
        end else if (useImm8) begin
            imm = {{(`DATA_WIDTH - 8){imm8[7] & ~zeroExt}}, imm8};
        end else begin
            imm = {{(`DATA_WIDTH - 5){imm5[4] & ~zeroExt}}, imm5};
        end
    end

endmodule

//--- logic/isaPkg.sv
`include "decodeStage_cfg.svh"

package isaPkg;

    // Major opcodes, instr[15:11]
    typedef enum logic [4:0] {
        OP_HALT  = 5'b00000,
        OP_NOP   = 5'b00001,
        OP_J     = 5'b00100,
        OP_JR    = 5'b00101,
        OP_JAL   = 5'b00110,
        OP_JALR  = 5'b00111,
        OP_ADDI  = 5'b01000,
        OP_SUBI  = 5'b01001,
        OP_XORI  = 5'b01010,
        OP_ANDNI = 5'b01011,
        OP_BEQZ  = 5'b01100,
        OP_BNEZ  = 5'b01101,
        OP_BLTZ  = 5'b01110,
        OP_BGEZ  = 5'b01111,
        OP_ST    = 5'b10000,
        OP_LD    = 5'b10001,
        OP_SLBI  = 5'b10010,
        OP_STU   = 5'b10011,
        OP_ROLI  = 5'b10100,
        OP_SLLI  = 5'b10101,
        OP_RORI  = 5'b10110,
        OP_SRLI  = 5'b10111,
        OP_LBI   = 5'b11000,
        OP_BTR   = 5'b11001,
        OP_SHFT  = 5'b11010,
        OP_ALU   = 5'b11011,
        OP_SEQ   = 5'b11100,
        OP_SLT   = 5'b11101,
        OP_SLE   = 5'b11110,
        OP_SCO   = 5'b11111
    } opcodeT;

    // Function field of the R-format arithmetic group
    localparam logic [1:0] FN_ADD  = 2'b00;
    localparam logic [1:0] FN_SUB  = 2'b01;
    localparam logic [1:0] FN_XOR  = 2'b10;
    localparam logic [1:0] FN_ANDN = 2'b11;

    // Function field of the R-format rotate and shift group
    localparam logic [1:0] FN_ROL = 2'b00;
    localparam logic [1:0] FN_SLL = 2'b01;
    localparam logic [1:0] FN_ROR = 2'b10;
    localparam logic [1:0] FN_SRL = 2'b11;

    typedef struct packed {
        opcodeT                opcode;
        logic [`REG_IDX_W-1:0] rs;
        logic [`REG_IDX_W-1:0] rt;
        logic [`REG_IDX_W-1:0] rd;
        logic [1:0]            func;
    } rFmtT;

    // Longer immediates overlay rs and rd of this view
    typedef struct packed {
        opcodeT                opcode;
        logic [`REG_IDX_W-1:0] rs;
        logic [`REG_IDX_W-1:0] rd;
        logic [4:0]            imm;
    } iFmtT;

    typedef union packed {
        rFmtT rFmt;
        iFmtT iFmt;
    } instrWordT;

endpackage

//--- logic/pipePkg.sv
`include "decodeStage_cfg.svh"

package pipePkg;

    // Compare ops use the seq and sl flags, rotates use ror for direction
    typedef enum logic [2:0] {
        ALU_ADD  = 3'b000,
        ALU_SUB  = 3'b001,
        ALU_XOR  = 3'b010,
        ALU_ANDN = 3'b011,
        ALU_ROT  = 3'b100,
        ALU_SHL  = 3'b101,
        ALU_SHR  = 3'b110,
        ALU_CMP  = 3'b111
    } aluOpT;

    // Branch control, bit 2 marks a branch and bits 1:0 pick the test
    localparam logic [2:0] BR_NONE = 3'b000;
    localparam logic [2:0] BR_EQZ  = 3'b100;
    localparam logic [2:0] BR_NEZ  = 3'b101;
    localparam logic [2:0] BR_LTZ  = 3'b110;
    localparam logic [2:0] BR_GEZ  = 3'b111;

    // Jump control as {jump, link, register target}
    localparam logic [2:0] JMP_NONE = 3'b000;
    localparam logic [2:0] JMP_J    = 3'b100;
    localparam logic [2:0] JMP_JR   = 3'b101;
    localparam logic [2:0] JMP_JAL  = 3'b110;
    localparam logic [2:0] JMP_JALR = 3'b111;

    typedef struct packed {
        aluOpT      aluOp;
        logic [2:0] jumpCtl;
        logic [2:0] branchCtl;
        logic       regWrite;
        logic       aluSrc;
        logic       btr;
        logic       memWrite;
        logic       memRead;
        logic       memToReg;
        logic       lbi;
        logic       slbi;
        logic       seq;
        logic       sl;
        logic       sco;
        logic       ror;
        logic       link;
        logic       halt;
        logic       illegal;
    } ctrlT;

    typedef struct packed {
        logic                   writes;
        logic [`REG_IDX_W-1:0]  rd;
        logic [`DATA_WIDTH-1:0] data;
    } fwdSrcT;

    typedef struct packed {
        logic                   en;
        logic [`REG_IDX_W-1:0]  sel;
        logic [`DATA_WIDTH-1:0] data;
    } wbPortT;

    typedef struct packed {
        ctrlT                   ctrl;
        logic [`REG_IDX_W-1:0]  rd;
        logic [`REG_IDX_W-1:0]  rs;
        logic [`REG_IDX_W-1:0]  rt;
        logic [`DATA_WIDTH-1:0] rsData;
        logic [`DATA_WIDTH-1:0] rtData;
        logic [`DATA_WIDTH-1:0] imm;
        logic [`DATA_WIDTH-1:0] pcInc;
    } dxBundleT;

endpackage

//--- logic/regFileBypass.sv
`timescale 1ns/1ps
`include "decodeStage_cfg.svh"

module regFileBypass
    import pipePkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic [`REG_IDX_W-1:0]  rdSelA,
    input  logic [`REG_IDX_W-1:0]  rdSelB,
    output logic [`DATA_WIDTH-1:0] rdDataA,
    output logic [`DATA_WIDTH-1:0] rdDataB,
    input  wbPortT                 wb
);

    logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];
    logic                   hitA;
    logic                   hitB;

    // Storage, written from the writeback port at the edge
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.en) begin
            regs[wb.sel] <= wb.data;
        end
    end

    // A write landing this cycle is seen by the reader right away
    assign hitA = wb.en && (wb.sel == rdSelA);
    assign hitB = wb.en && (wb.sel == rdSelB);

    always_comb begin
        if (hitA) begin
            rdDataA = wb.data;
        end else begin
            rdDataA = regs[rdSelA];
        end
    end

    always_comb begin
        if (hitB) begin
            rdDataB = wb.data;
        end else begin
            rdDataB = regs[rdSelB];
        end
    end

endmodule

//--- runSim.sh
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module decodeStageTb \
    && ./obj_dir/VdecodeStageTb | tee /dev/stderr | grep -q "ALL CHECKS PASSED" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- verif/decodeStageTb.sv
`timescale 1ns/1ps
`include "decodeStage_cfg.svh"

module decodeStageTb
    import isaPkg::*, pipePkg::*;
();

    localparam int MAX_VEC = 64;

    // One test line with stimulus first and expected response after
    typedef struct packed {
        instrWordT              instr;
        logic [`DATA_WIDTH-1:0] pcInc;
        wbPortT                 wb;
        fwdSrcT                 exFwd;
        fwdSrcT                 memFwd;
        dxBundleT               expDx;
        logic                   expRedirect;
        logic [`DATA_WIDTH-1:0] expPcNew;
    } vectorT;

    logic                   clk;
    logic                   reset;
    logic                   inValid;
    logic                   inReady;
    instrWordT              instr;
    logic [`DATA_WIDTH-1:0] pcInc;
    wbPortT                 wb;
    fwdSrcT                 exFwd;
    fwdSrcT                 memFwd;
    logic                   dxValid;
    logic                   dxReady;
    dxBundleT               dx;
    logic                   redirect;
    logic [`DATA_WIDTH-1:0] pcNew;

    vectorT      vectors [MAX_VEC];
    int          vecErrors [MAX_VEC];
    int          numVec;
    int          curVec;
    dxBundleT    expQ [$];
    int          idxQ [$];
    int          errorCount;
    int          checkCount;
    int          outCount;
    int          cycleLimit;
    logic [31:0] rngState;

    decodeStage u_dut (
        .clk      (clk),
        .reset    (reset),
        .inValid  (inValid),
        .inReady  (inReady),
        .instr    (instr),
        .pcInc    (pcInc),
        .wb       (wb),
        .exFwd    (exFwd),
        .memFwd   (memFwd),
        .dxValid  (dxValid),
        .dxReady  (dxReady),
        .dx       (dx),
        .redirect (redirect),
        .pcNew    (pcNew)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] nextRandom(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic checkValue(input string name, input logic [23:0] expV, input logic [23:0] actV);
        checkCount++;
        assert (expV == actV) else begin
            $display("[FAIL] t=%0t %s expected %h got %h", $time, name, expV, actV);
            errorCount++;
            vecErrors[curVec]++;
        end
    endtask

    task automatic readVectors(output bit ok);
        int                     fd;
        int                     n;
        string                  line;
        logic [15:0]            fInstr;
        logic [15:0]            fPc;
        logic [19:0]            fWb;
        logic [19:0]            fEx;
        logic [19:0]            fMem;
        logic [23:0]            fCtrl;
        logic [2:0]             fRd;
        logic [2:0]             fRs;
        logic [2:0]             fRt;
        logic [15:0]            fRsD;
        logic [15:0]            fRtD;
        logic [15:0]            fImm;
        logic                   fRedir;
        logic [15:0]            fPcNew;
        ok = 1'b1;
        numVec = 0;
        fd = $fopen("verif/decodeVectors.hex", "r");
        if (fd == 0) begin
            $display("could not open the vector file");
            ok = 1'b0;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 8 || line.substr(0, 1) == "//") begin
                continue;
            end
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h", fInstr, fPc,
                        fWb, fEx, fMem, fCtrl, fRd, fRs, fRt, fRsD, fRtD, fImm, fRedir, fPcNew);
            if (n != 14 || numVec >= MAX_VEC) begin
                $display("malformed or excess vector line: %s", line);
                ok = 1'b0;
            end else begin
                vectors[numVec].instr        = instrWordT'(fInstr);
                vectors[numVec].pcInc        = fPc;
                vectors[numVec].wb           = wbPortT'(fWb);
                vectors[numVec].exFwd        = fwdSrcT'(fEx);
                vectors[numVec].memFwd       = fwdSrcT'(fMem);
                vectors[numVec].expDx.ctrl   = ctrlT'(fCtrl);
                vectors[numVec].expDx.rd     = fRd;
                vectors[numVec].expDx.rs     = fRs;
                vectors[numVec].expDx.rt     = fRt;
                vectors[numVec].expDx.rsData = fRsD;
                vectors[numVec].expDx.rtData = fRtD;
                vectors[numVec].expDx.imm    = fImm;
                vectors[numVec].expDx.pcInc  = fPc;
                vectors[numVec].expRedirect  = fRedir;
                vectors[numVec].expPcNew     = fPcNew;
                vecErrors[numVec] = 0;
                numVec++;
            end
        end
        $fclose(fd);
    endtask

    // Inputs change 2 ns after the edge and dxReady follows the random stream
    task automatic driveInputs(input int idx);
        rngState = nextRandom(rngState);
        dxReady  = (rngState[1:0] != 2'b00);
        if (idx < numVec) begin
            inValid = 1'b1;
            instr   = vectors[idx].instr;
            pcInc   = vectors[idx].pcInc;
            wb      = vectors[idx].wb;
            exFwd   = vectors[idx].exFwd;
            memFwd  = vectors[idx].memFwd;
        end else begin
            inValid = 1'b0;
            wb      = '0;
            exFwd   = '0;
            memFwd  = '0;
        end
    endtask

    task automatic compareBundle(input dxBundleT e, input int vecIdx);
        curVec = vecIdx;
        checkValue("dx.ctrl", e.ctrl, dx.ctrl);
        checkValue("dx.rd", e.rd, dx.rd);
        checkValue("dx.rs", e.rs, dx.rs);
        checkValue("dx.rt", e.rt, dx.rt);
        checkValue("dx.rsData", e.rsData, dx.rsData);
        checkValue("dx.rtData", e.rtData, dx.rtData);
        checkValue("dx.imm", e.imm, dx.imm);
        checkValue("dx.pcInc", e.pcInc, dx.pcInc);
    endtask

    initial begin
        int cycles;
        cycles = 0;
        wait (cycleLimit > 0);
        while (cycles < cycleLimit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", cycleLimit);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        bit       ok;
        bit       stalled;
        int       idx;
        int       vecIdx;
        dxBundleT held;
        reset      = 1'b1;
        inValid    = 1'b0;
        instr      = '0;
        pcInc      = '0;
        wb         = '0;
        exFwd      = '0;
        memFwd     = '0;
        dxReady    = 1'b0;
        errorCount = 0;
        checkCount = 0;
        outCount   = 0;
        cycleLimit = 0;
        curVec     = 0;
        rngState   = 32'h351bc22b;
        readVectors(ok);
        if (!ok || numVec == 0) begin
            $display("vector file missing, empty or malformed");
            $display("CHECKS FAILED");
            $finish;
        end else begin
            cycleLimit = 8 * numVec + 20;
            repeat (2) @(posedge clk);
            #2 reset = 1'b0;
            @(negedge clk);
            checkCount++;
            assert (dxValid == 1'b0) else begin
                $display("[FAIL] t=%0t dxValid expected 0 got %b", $time, dxValid);
                errorCount++;
            end
            @(posedge clk);
            #2;
            idx     = 0;
            stalled = 1'b0;
            held    = '0;
            driveInputs(idx);
            while (outCount < numVec) begin
                @(negedge clk);
                if (stalled) begin
                    checkCount++;
                    assert (dx == held) else begin
                        $display("[FAIL] t=%0t dx expected %h got %h", $time, held, dx);
                        errorCount++;
                    end
                end
                if (dxValid && !dxReady) begin
                    checkCount++;
                    assert (!inReady) else begin
                        $display("[FAIL] t=%0t inReady expected 0 got %b", $time, inReady);
                        errorCount++;
                    end
                end else begin
                    checkCount++;
                    assert (inReady) else begin
                        $display("[FAIL] t=%0t inReady expected 1 got %b", $time, inReady);
                        errorCount++;
                    end
                end
                // Redirect is judged in the acceptance cycle
                if (inValid && inReady) begin
                    curVec = idx;
                    checkValue("redirect", vectors[idx].expRedirect, redirect);
                    if (vectors[idx].expRedirect) begin
                        checkValue("pcNew", vectors[idx].expPcNew, pcNew);
                    end
                    expQ.push_back(vectors[idx].expDx);
                    idxQ.push_back(idx);
                    idx++;
                end else begin
                    checkCount++;
                    assert (!redirect) else begin
                        $display("[FAIL] t=%0t redirect expected 0 got %b", $time, redirect);
                        errorCount++;
                    end
                end
                if (dxValid && dxReady) begin
                    if (expQ.size() == 0) begin
                        $display("t=%0t dx transfer with no instruction outstanding", $time);
                        errorCount++;
                    end else begin
                        vecIdx = idxQ.pop_front();
                        compareBundle(expQ.pop_front(), vecIdx);
                        $display("vector %0d %s", vecIdx,
                                 (vecErrors[vecIdx] == 0) ? "ok" : "mismatch");
                    end
                    outCount++;
                end
                stalled = dxValid && !dxReady;
                held    = dx;
                @(posedge clk);
                #2;
                driveInputs(idx);
            end
            // Output register drains once the last instruction has left
            @(negedge clk);
            checkCount++;
            assert (!dxValid) else begin
                $display("[FAIL] t=%0t dxValid expected 0 got %b", $time, dxValid);
                errorCount++;
            end
            $display("%0d vectors, %0d checks, %0d errors", numVec, checkCount, errorCount);
            if (errorCount == 0) begin
                $display("ALL CHECKS PASSED");
            end else begin
                $display("CHECKS FAILED");
            end
            $finish;
        end
    end

endmodule

//--- verif/decodeVectors.hex
// instr pcInc wb{en,sel,data} exFwd{wr,rd,data} memFwd{wr,rd,data}
// expected: ctrl rd rs rt rsData rtData imm redirect pcNew (pcNew only if redirect)
// Register write-through and readback
D908 0100 91234 00000 00000 004000 2 1 0 1234 0000 0008 0 0000
D94D 0102 ABEEF 00000 00000 204000 3 1 2 1234 BEEF 000D 0 0000
DA32 0104 00000 00000 00000 404000 4 2 1 BEEF 1234 FFF2 0 0000
DDBB 0106 D8001 00000 00000 604000 6 5 5 8001 8001 FFFB 0 0000
// R-format groups
D15C 0108 00000 00000 00000 804000 7 1 2 1234 BEEF FFFC 0 0000
D006 010A 00000 00000 00000 804008 1 0 0 0000 0000 0006 0 0000
E14C 010C 00000 00000 00000 E04040 3 1 2 1234 BEEF 000C 0 0000
ED28 010E 00000 00000 00000 E04020 2 5 1 8001 1234 0008 0 0000
F0B0 0110 00000 00000 00000 E04060 4 0 5 0000 8001 FFF0 0 0000
FA54 0112 00000 00000 00000 004010 5 2 2 BEEF BEEF FFF4 0 0000
C918 0114 00000 00000 00000 005000 6 1 0 1234 0000 FFF8 0 0000
// I-format, xori and andni zero-extended
4171 0116 00000 00000 00000 006000 3 1 3 1234 0000 FFF1 0 0000
4A87 0118 00000 00000 00000 206000 4 2 4 BEEF 0000 0007 0 0000
553F 011A 00000 00000 00000 406000 1 5 1 8001 1234 001F 0 0000
5850 011C 00000 00000 00000 606000 2 0 2 0000 BEEF 0010 0 0000
AA64 011E 00000 00000 00000 A06000 3 2 3 BEEF 0000 0004 0 0000
B5C1 0120 00000 00000 00000 806008 6 5 6 8001 0000 0001 0 0000
// Memory, byte immediates, nop, halt, unused opcodes
8942 0122 00000 00000 00000 006600 2 1 2 1234 BEEF 0002 0 0000
82BE 0124 00000 00000 00000 002800 5 2 5 BEEF 8001 FFFE 0 0000
9D25 0126 00000 00000 00000 006800 5 5 1 8001 1234 0005 0 0000
C385 0128 00000 00000 00000 004100 3 3 4 0000 0000 FF85 0 0000
96F0 012A 00000 00000 00000 004080 6 6 7 0000 0000 00F0 0 0000
0800 012C 00000 00000 00000 000000 0 0 0 0000 0000 0000 0 0000
0000 012E 00000 00000 00000 000002 0 0 0 0000 0000 0000 0 0000
1141 0130 00000 00000 00000 000001 2 1 2 1234 BEEF 0001 0 0000
1800 0132 00000 00000 00000 000001 0 0 0 0000 0000 0000 0 0000
// Branches on zero, positive and negative Rs
6010 0200 00000 00000 00000 020000 0 0 0 0000 0000 0010 1 0210
61F0 0200 00000 00000 00000 020000 7 1 7 1234 0000 FFF0 0 0000
6DFC 0200 00000 00000 00000 028000 7 5 7 8001 0000 FFFC 1 01FC
6804 0200 00000 00000 00000 028000 0 0 0 0000 0000 0004 0 0000
7508 0200 00000 00000 00000 030000 0 5 0 8001 0000 0008 1 0208
7108 0200 00000 00000 00000 030000 0 1 0 1234 0000 0008 0 0000
7820 0200 00000 00000 00000 038000 1 0 1 0000 1234 0020 1 0220
7A20 0200 00000 00000 00000 038000 1 2 1 BEEF 1234 0020 0 0000
7902 0200 00000 00000 00000 038000 0 1 0 1234 0000 0002 1 0202
// Jumps
27FE 0300 00000 00000 00000 100000 7 7 7 0000 0000 FFFE 1 02FE
3040 0300 00000 00000 00000 184004 7 0 2 0000 BEEF 0040 1 0340
2910 0300 00000 00000 00000 140000 0 1 0 1234 0000 0010 1 1244
3DFF 0300 00000 00000 00000 1C4004 7 5 7 8001 0000 FFFF 1 8000
// Forwarding priority for Rs
2902 0400 00000 94000 00000 140000 0 1 0 1234 0000 0002 1 4002
2902 0400 00000 00000 95000 140000 0 1 0 1234 0000 0002 1 5002
2902 0400 00000 94000 95000 140000 0 1 0 1234 0000 0002 1 4002
2902 0400 00000 A7777 95000 140000 0 1 0 1234 0000 0002 1 5002
6104 0400 00000 90000 00000 020000 0 1 0 1234 0000 0004 1 0404
7106 0400 00000 00000 98000 030000 0 1 0 1234 0000 0006 1 0406
7106 0400 00000 90001 98000 030000 0 1 0 1234 0000 0006 0 0000
6804 0400 00000 0FFFF 00000 028000 0 0 0 0000 0000 0004 0 0000

//--- vlog.f
+incdir+include
logic/isaPkg.sv
logic/pipePkg.sv
logic/regFileBypass.sv
logic/immExtend.sv
logic/controlDecode.sv
logic/branchResolve.sv
logic/decodeStage.sv
verif/decodeStageTb.sv
